// ==== golden_exec.txt ====
# instr    wbEn wbReg wbData   nextPc   (all hex, one instruction per line)
# wbReg and wbData are only compared when wbEn is 1
20010005 1 01 00000005 00000004
2002FFFD 1 02 FFFFFFFD 00000008
304300F0 1 03 000000F0 0000000C
34248000 1 04 00008005 00000010
3845FFFF 1 05 FFFF0002 00000014
28460001 1 06 00000001 00000018
2827FFFF 1 07 00000000 0000001C
00224020 1 08 00000002 00000020
00224822 1 09 00000008 00000024
70445002 1 0A FFFE7FF1 00000028
00A25824 1 0B FFFF0000 0000002C
00616025 1 0C 000000F5 00000030
00236827 1 0D FFFFFF0A 00000034
00857026 1 0E FFFF8007 00000038
0041782A 1 0F 00000001 0000003C
00018100 1 10 00000050 00000040
00408A02 1 11 00FFFFFF 00000044
20200007 1 00 0000000C 00000048
00019020 1 12 00000005 0000004C
14220002 0 00 00000000 00000058
14320002 0 00 00000000 0000005C
0440FFFE 0 00 00000000 00000058
04200004 0 00 00000000 0000005C
18000003 0 00 00000000 0000006C
18200003 0 00 00000000 00000070
1C200004 0 00 00000000 00000084
1C400004 0 00 00000000 00000088
04010001 0 00 00000000 00000090
04410001 0 00 00000000 00000094
01600008 0 00 00000000 FFFF0000
08000100 0 00 00000000 F0000400
20330001 1 13 00000006 F0000404

// ==== list.f ====
mipsPkg.sv
alu32.sv
instrDecoder.sv
regFile.sv
pcCounter.sv
execController.sv
mipsExecTop.sv
tbMipsExec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MIPS execute testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps -f list.f \
        --top-module tbMipsExec --Mdir obj_dir -o tbMipsExec; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tbMipsExec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
    exit 0
fi
exit 1

// ==== tbMipsExec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMipsExec;

    localparam int halfPeriod = 50;      // 100 ns clock
    localparam int maxVectors = 64;

    logic        Clk;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        ready;
    logic        done;
    logic        wbEn;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic [31:0] pc;

    // Golden columns, one entry per instruction
    logic [31:0] goldInstr  [maxVectors];
    logic [31:0] goldWbEn   [maxVectors];
    logic [31:0] goldWbReg  [maxVectors];
    logic [31:0] goldWbData [maxVectors];
    logic [31:0] goldPc     [maxVectors];

    int   vecCount;
    int   errorCount;
    int   checkCount;
    logic loaded;                        // Releases the watchdog

    mipsExecTop u_dut (
        .Clk, .rstN, .instrValid, .instr,
        .ready, .done, .wbEn, .wbReg, .wbData, .pc
    );

    always #(halfPeriod) Clk = ~Clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic loadGolden();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] colInstr;
        logic [31:0] colWbEn;
        logic [31:0] colWbReg;
        logic [31:0] colWbData;
        logic [31:0] colPc;
        fd = $fopen("golden_exec.txt", "r");
        if (fd == 0) begin
            $display("Could not open golden_exec.txt for reading");
            errorCount++;
        end else begin
            while (!$feof(fd) && vecCount < maxVectors) begin
                line   = "";
                fields = $fgets(line, fd);
                if (line.len() > 0 && line.substr(0, 0) != "#") begin  // Skip column notes
                    fields = $sscanf(line, "%h %h %h %h %h",
                                     colInstr, colWbEn, colWbReg, colWbData, colPc);
                    if (fields == 5) begin
                        goldInstr[vecCount]  = colInstr;
                        goldWbEn[vecCount]   = colWbEn;
                        goldWbReg[vecCount]  = colWbReg;
                        goldWbData[vecCount] = colWbData;
                        goldPc[vecCount]     = colPc;
                        vecCount++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Entered on a falling edge with the DUT idle
    task automatic runVector(input int idx);
        instrValid = 1'b1;
        instr      = goldInstr[idx];
        @(negedge Clk);
        instr = ~goldInstr[idx];         // Stray strobe while busy, must be dropped
        @(negedge Clk);
        instrValid = 1'b0;
        instr      = 32'd0;
        while (done !== 1'b1) begin
            @(negedge Clk);
        end
        checkValue($sformatf("vector %0d wbEn", idx), {31'd0, wbEn}, goldWbEn[idx]);
        if (goldWbEn[idx] != 32'd0) begin   // Destination only meaningful on a write
            checkValue($sformatf("vector %0d wbReg", idx), {27'd0, wbReg}, goldWbReg[idx]);
            checkValue($sformatf("vector %0d wbData", idx), wbData, goldWbData[idx]);
        end
        @(negedge Clk);
        checkValue($sformatf("vector %0d pc", idx), pc, goldPc[idx]);  // New PC now visible
        checkValue($sformatf("vector %0d ready", idx), {31'd0, ready}, 32'd1);
        checkValue($sformatf("vector %0d done", idx), {31'd0, done}, 32'd0);  // One-cycle pulse
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        Clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = 32'd0;
        errorCount = 0;
        checkCount = 0;
        vecCount   = 0;
        loaded     = 1'b0;

        loadGolden();
        if (vecCount == 0) begin
            $display("No instructions were read from golden_exec.txt");
            errorCount++;
        end
        loaded = 1'b1;

        repeat (5) @(posedge Clk);       // Reset held for 5 cycles
        @(negedge Clk);
        rstN = 1'b1;

        // State straight out of reset
        checkValue("reset pc", pc, 32'd0);
        checkValue("reset ready", {31'd0, ready}, 32'd1);
        checkValue("reset done", {31'd0, done}, 32'd0);
        checkValue("reset wbEn", {31'd0, wbEn}, 32'd0);

        for (int i = 0; i < vecCount; i++) begin
            runVector(i);
        end

        $display("%0d errors in %0d checks over %0d instructions",
                 errorCount, checkCount, vecCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog, sized from the instruction count
    initial begin
        wait (loaded);
        repeat (vecCount * 6 + 20) @(posedge Clk);
        $display("Timeout: the run did not complete within %0d clock cycles",
                 vecCount * 6 + 20);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mipsExecTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsExecTop (
    input  wire logic        Clk,
    input  wire logic        rstN,
    input  wire logic        instrValid,
    input  wire logic [31:0] instr,
    output logic             ready,
    output logic             done,
    output logic             wbEn,
    output logic      [4:0]  wbReg,
    output logic      [31:0] wbData,
    output logic      [31:0] pc
);

    mipsPkg::instrWordT instrLatched;
    logic [4:0]         aluCtrl;
    logic               selShamtA;
    logic               selShamtB;
    logic               selImm;
    logic               immSigned;
    logic               selPcA;
    logic               decWbEn;
    logic               wbUseRt;
    logic               isBranch;
    logic               isJump;
    logic [4:0]         rsAddr;
    logic [4:0]         rtAddr;
    logic [31:0]        rdDataA;
    logic [31:0]        rdDataB;
    logic [31:0]        opA;
    logic [31:0]        opB;
    logic [31:0]        aluResult;
    logic               zero;
    logic               pcStep;
    logic               pcTake;
    logic [31:0]        pcTarget;
    logic [31:0]        pcPlus4;

    execController u_ctrl (
        .Clk, .rstN, .instrValid, .instr, .ready, .done,
        .selShamtA, .selShamtB, .selImm, .immSigned, .selPcA,
        .decWbEn, .wbUseRt, .isBranch, .isJump,
        .rdDataA, .rdDataB, .pcPlus4, .aluResult, .zero,
        .opA, .opB, .rsAddr, .rtAddr, .instrLatched,
        .wbEn, .wbReg, .wbData, .pcStep, .pcTake, .pcTarget
    );

    instrDecoder u_dec (
        .instr (instrLatched),
        .aluCtrl, .selShamtA, .selShamtB, .selImm, .immSigned, .selPcA,
        .wbEn  (decWbEn),
        .wbUseRt, .isBranch, .isJump
    );

    // Register writes share the controller's writeback strobe
    regFile u_rf (
        .Clk, .rstN,
        .rdAddrA (rsAddr),
        .rdAddrB (rtAddr),
        .rdDataA, .rdDataB,
        .wrEn    (wbEn),
        .wrAddr  (wbReg),
        .wrData  (wbData)
    );

    alu32 u_alu (
        .aluCtrl,
        .A (opA),
        .B (opB),
        .aluResult, .zero
    );

    pcCounter u_pc (
        .Clk, .rstN, .pcStep, .pcTake, .pcTarget, .pc, .pcPlus4
    );

endmodule

`default_nettype wire

// ==== execController.sv ====
`timescale 1ns/1ps
`default_nettype none

module execController (
    input  wire logic               Clk,
    input  wire logic               rstN,
    input  wire logic               instrValid,
    input  wire logic [31:0]        instr,
    output logic                    ready,
    output logic                    done,
    // Decoder selects
    input  wire logic               selShamtA,
    input  wire logic               selShamtB,
    input  wire logic               selImm,
    input  wire logic               immSigned,
    input  wire logic               selPcA,
    input  wire logic               decWbEn,
    input  wire logic               wbUseRt,
    input  wire logic               isBranch,
    input  wire logic               isJump,
    // Datapath
    input  wire logic [31:0]        rdDataA,
    input  wire logic [31:0]        rdDataB,
    input  wire logic [31:0]        pcPlus4,
    input  wire logic [31:0]        aluResult,
    input  wire logic               zero,
    output logic      [31:0]        opA,
    output logic      [31:0]        opB,
    output logic      [4:0]         rsAddr,
    output logic      [4:0]         rtAddr,
    output mipsPkg::instrWordT      instrLatched,
    // Writeback and PC update
    output logic                    wbEn,
    output logic      [4:0]         wbReg,
    output logic      [31:0]        wbData,
    output logic                    pcStep,
    output logic                    pcTake,
    output logic      [31:0]        pcTarget
);

    mipsPkg::stateT state;
    logic [31:0]    immExt;
    logic [31:0]    brOffset;
    logic [31:0]    opANext;
    logic [31:0]    opBNext;
    logic [31:0]    resultReg;
    logic           zeroReg;

    ////////////////////////////////////////////////////////////////////////////
    // FSM with one pass per instruction
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= mipsPkg::ST_IDLE;
        end else begin
            case (state)
                mipsPkg::ST_IDLE:  if (instrValid) state <= mipsPkg::ST_READ;
                mipsPkg::ST_READ:  state <= mipsPkg::ST_EXEC;
                mipsPkg::ST_EXEC:  state <= mipsPkg::ST_WRITE;
                default:           state <= mipsPkg::ST_IDLE;
            endcase
        end
    end

    assign ready = (state == mipsPkg::ST_IDLE);   // Strobes dropped otherwise
    assign done  = (state == mipsPkg::ST_WRITE);

    assign rsAddr = instrLatched.r.rs;
    assign rtAddr = instrLatched.r.rt;

    // Operand selection
    assign immExt = immSigned ? {{16{instrLatched.i.imm[15]}}, instrLatched.i.imm}
                              : {16'd0, instrLatched.i.imm};

    always_comb begin
        opANext = rdDataA;
        if (selShamtA) begin
            opANext = {27'd0, instrLatched.r.shamt};
        end else if (selPcA) begin
            opANext = pcPlus4;                    // Supplies top 4 bits
        end

        opBNext = rdDataB;
        if (selShamtB) begin
            opBNext = {27'd0, instrLatched.r.shamt};
        end else if (selImm) begin
            opBNext = immExt;
        end else if (selPcA) begin
            opBNext = {6'd0, instrLatched.j.target};
        end
    end

    // Payload registers loaded by state
    always_ff @(posedge Clk) begin
        if (ready && instrValid) begin
            instrLatched <= instr;
        end
        if (state == mipsPkg::ST_READ) begin
            opA <= opANext;
            opB <= opBNext;
        end
        if (state == mipsPkg::ST_EXEC) begin
            resultReg <= aluResult;
            zeroReg   <= zero;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writeback and PC update live during ST_WRITE
    ////////////////////////////////////////////////////////////////////////////
    assign wbEn   = done && decWbEn;
    assign wbReg  = wbUseRt ? instrLatched.i.rt : instrLatched.r.rd;
    assign wbData = resultReg;

    // Signed word offset as a byte count
    assign brOffset = {{14{instrLatched.i.imm[15]}}, instrLatched.i.imm, 2'b00};

    assign pcStep   = done;
    assign pcTake   = isBranch ? zeroReg : isJump;   // Zero means branch taken
    assign pcTarget = isBranch ? pcPlus4 + brOffset
                               : resultReg;          // j and jr from ALU

endmodule

`default_nettype wire

// ==== pcCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcCounter (
    input  wire logic        Clk,
    input  wire logic        rstN,
    input  wire logic        pcStep,     // One pulse per instruction
    input  wire logic        pcTake,     // Redirect instead of +4
    input  wire logic [31:0] pcTarget,
    output logic      [31:0] pc,
    output logic      [31:0] pcPlus4
);

    assign pcPlus4 = pc + 32'd4;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc <= 32'd0;
        end else if (pcStep) begin
            pc <= pcTake ? pcTarget : pcPlus4;
        end
    end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic        Clk,
    input  wire logic        rstN,
    input  wire logic [4:0]  rdAddrA,
    input  wire logic [4:0]  rdAddrB,
    output logic      [31:0] rdDataA,
    output logic      [31:0] rdDataB,
    input  wire logic        wrEn,
    input  wire logic [4:0]  wrAddr,
    input  wire logic [31:0] wrData
);

    logic [31:0] regs [32];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;              // $zero never written
        end
    end

    // Async read ports, $zero hard-wired
    assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire mipsPkg::instrWordT instr,
    output logic [4:0] aluCtrl,
    output logic       selShamtA,   // sll amount on A
    output logic       selShamtB,   // srl amount on B
    output logic       selImm,      // Immediate on B
    output logic       immSigned,
    output logic       selPcA,      // j: pc+4 on A, target on B
    output logic       wbEn,
    output logic       wbUseRt,     // I-type destination
    output logic       isBranch,
    output logic       isJump       // j and jr
);

    always_comb begin
        // Safe default is a no-write add, pc just steps
        aluCtrl   = mipsPkg::ALU_ADD;
        selShamtA = 1'b0;
        selShamtB = 1'b0;
        selImm    = 1'b0;
        immSigned = 1'b0;
        selPcA    = 1'b0;
        wbEn      = 1'b0;
        wbUseRt   = 1'b0;
        isBranch  = 1'b0;
        isJump    = 1'b0;

        case (instr.r.opcode)
            mipsPkg::OP_RTYPE: begin
                wbEn = 1'b1;
                case (instr.r.funct)
                    mipsPkg::FN_ADD: aluCtrl = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUB: aluCtrl = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND: aluCtrl = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:  aluCtrl = mipsPkg::ALU_OR;
                    mipsPkg::FN_NOR: aluCtrl = mipsPkg::ALU_NOR;
                    mipsPkg::FN_XOR: aluCtrl = mipsPkg::ALU_XOR;
                    mipsPkg::FN_SLT: aluCtrl = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLL: begin
                        aluCtrl   = mipsPkg::ALU_SLL;
                        selShamtA = 1'b1;
                    end
                    mipsPkg::FN_SRL: begin
                        aluCtrl   = mipsPkg::ALU_SRL;
                        selShamtB = 1'b1;
                    end
                    mipsPkg::FN_JR: begin
                        aluCtrl = mipsPkg::ALU_JR;
                        wbEn    = 1'b0;
                        isJump  = 1'b1;
                    end
                    default: wbEn = 1'b0;       // Unknown funct, no write
                endcase
            end
            mipsPkg::OP_MUL: begin
                if (instr.r.funct == mipsPkg::FN_MUL) begin
                    aluCtrl = mipsPkg::ALU_MUL;
                    wbEn    = 1'b1;
                end
            end

            // I-type ALU ops write rt
            mipsPkg::OP_ADDI, mipsPkg::OP_SLTI: begin
                aluCtrl   = (instr.i.opcode == mipsPkg::OP_SLTI) ?
                            mipsPkg::ALU_SLT : mipsPkg::ALU_ADD;
                selImm    = 1'b1;
                immSigned = 1'b1;
                wbEn      = 1'b1;
                wbUseRt   = 1'b1;
            end
            mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_XORI: begin
                case (instr.i.opcode)
                    mipsPkg::OP_ANDI: aluCtrl = mipsPkg::ALU_AND;
                    mipsPkg::OP_ORI:  aluCtrl = mipsPkg::ALU_OR;
                    default:          aluCtrl = mipsPkg::ALU_XOR;
                endcase
                selImm  = 1'b1;                  // Zero-extended
                wbEn    = 1'b1;
                wbUseRt = 1'b1;
            end

            ////////////////////////////////////////////////////////////////////
            // Branches and jump
            ////////////////////////////////////////////////////////////////////
            mipsPkg::OP_BNE: begin
                aluCtrl  = mipsPkg::ALU_BNE;
                isBranch = 1'b1;
            end
            mipsPkg::OP_REGIMM: begin
                if (instr.i.rt == 5'd0) begin
                    aluCtrl  = mipsPkg::ALU_BLTZ;
                    isBranch = 1'b1;
                end else if (instr.i.rt == 5'd1) begin
                    aluCtrl  = mipsPkg::ALU_BGEZ;
                    isBranch = 1'b1;
                end
            end
            mipsPkg::OP_BLEZ: begin
                aluCtrl  = mipsPkg::ALU_BLEZ;
                isBranch = 1'b1;
            end
            mipsPkg::OP_BGTZ: begin
                aluCtrl  = mipsPkg::ALU_BGTZ;
                isBranch = 1'b1;
            end
            mipsPkg::OP_J: begin
                aluCtrl = mipsPkg::ALU_JADDR;
                selPcA  = 1'b1;
                isJump  = 1'b1;
            end
            default: ;                           // Falls back to no-write add
        endcase
    end

endmodule

`default_nettype wire

// ==== alu32.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu32 (
    input  wire logic        [4:0]  aluCtrl,
    input  wire logic signed [31:0] A,
    input  wire logic signed [31:0] B,
    output logic signed      [31:0] aluResult,
    output logic                    zero
);

    always_comb begin
        zero = 1'b0;
        case (aluCtrl)
            mipsPkg::ALU_ADD: aluResult = A + B;
            mipsPkg::ALU_SUB: aluResult = A - B;
            mipsPkg::ALU_MUL: aluResult = A * B;      // Low word only
            mipsPkg::ALU_AND: aluResult = A & B;
            mipsPkg::ALU_OR:  aluResult = A | B;
            mipsPkg::ALU_NOR: aluResult = ~(A | B);
            mipsPkg::ALU_XOR: aluResult = A ^ B;
            mipsPkg::ALU_SLL: aluResult = B << A[4:0];  // Amount rides on A
            mipsPkg::ALU_SRL: aluResult = A >> B[4:0];  // Logical, sign ignored
            mipsPkg::ALU_SLT: aluResult = (A < B) ? 32'd1 : 32'd0;

            // Branches give 0 when taken, so Zero means take
            mipsPkg::ALU_BLTZ: aluResult = (A < 0) ? 32'd0 : 32'd1;
            mipsPkg::ALU_BNE:  aluResult = (A != B) ? 32'd0 : 32'd1;
            mipsPkg::ALU_BLEZ: aluResult = (A <= 0) ? 32'd0 : 32'd1;
            mipsPkg::ALU_BGTZ: aluResult = (A > 0) ? 32'd0 : 32'd1;
            mipsPkg::ALU_BGEZ: aluResult = (A >= 0) ? 32'd0 : 32'd1;

            mipsPkg::ALU_JR: begin
                aluResult = A;                        // Target straight from rs
                zero      = 1'b1;
            end
            mipsPkg::ALU_JADDR: begin
                // Region bits from pc+4, word index from the J field
                aluResult = {A[31:28], B[25:0], 2'b00};
                zero      = 1'b1;
            end
            default: aluResult = 32'd0;
        endcase

        if (aluResult == 32'd0) begin
            zero = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [5:0] OP_RTYPE  = 6'b000000;  // SPECIAL, funct decides
    localparam logic [5:0] OP_MUL    = 6'b011100;  // SPECIAL2
    localparam logic [5:0] OP_ADDI   = 6'b001000;
    localparam logic [5:0] OP_ANDI   = 6'b001100;
    localparam logic [5:0] OP_ORI    = 6'b001101;
    localparam logic [5:0] OP_XORI   = 6'b001110;
    localparam logic [5:0] OP_SLTI   = 6'b001010;
    localparam logic [5:0] OP_BNE    = 6'b000101;
    localparam logic [5:0] OP_REGIMM = 6'b000001;  // rt 0 bltz, rt 1 bgez
    localparam logic [5:0] OP_BLEZ   = 6'b000110;
    localparam logic [5:0] OP_BGTZ   = 6'b000111;
    localparam logic [5:0] OP_J      = 6'b000010;

    // Funct field codes
    localparam logic [5:0] FN_ADD = 6'b100000;
    localparam logic [5:0] FN_SUB = 6'b100010;
    localparam logic [5:0] FN_MUL = 6'b000010;  // Only under OP_MUL
    localparam logic [5:0] FN_AND = 6'b100100;
    localparam logic [5:0] FN_OR  = 6'b100101;
    localparam logic [5:0] FN_NOR = 6'b100111;
    localparam logic [5:0] FN_XOR = 6'b100110;
    localparam logic [5:0] FN_SLL = 6'b000000;
    localparam logic [5:0] FN_SRL = 6'b000010;
    localparam logic [5:0] FN_SLT = 6'b101010;
    localparam logic [5:0] FN_JR  = 6'b001000;

    ////////////////////////////////////////////////////////////////////////////
    // ALU control codes
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [4:0] ALU_ADD   = 5'b00000;
    localparam logic [4:0] ALU_SUB   = 5'b00001;
    localparam logic [4:0] ALU_MUL   = 5'b00010;
    localparam logic [4:0] ALU_AND   = 5'b00011;
    localparam logic [4:0] ALU_OR    = 5'b00100;
    localparam logic [4:0] ALU_NOR   = 5'b00101;
    localparam logic [4:0] ALU_XOR   = 5'b00110;
    localparam logic [4:0] ALU_SLL   = 5'b00111;  // B << A
    localparam logic [4:0] ALU_SRL   = 5'b01000;  // A >> B
    localparam logic [4:0] ALU_SLT   = 5'b01001;
    localparam logic [4:0] ALU_BLTZ  = 5'b01110;
    localparam logic [4:0] ALU_BNE   = 5'b01111;
    localparam logic [4:0] ALU_JR    = 5'b10000;
    localparam logic [4:0] ALU_BLEZ  = 5'b10001;
    localparam logic [4:0] ALU_BGTZ  = 5'b10010;
    localparam logic [4:0] ALU_BGEZ  = 5'b10011;
    localparam logic [4:0] ALU_JADDR = 5'b10100;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,
        ST_EXEC  = 2'd2,
        ST_WRITE = 2'd3
    } stateT;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instrWordT;

endpackage

`default_nettype wire
